//--- filelist.f
design/fb_pkg.sv
design/fb_regs.sv
design/draw_engine.sv
design/frame_ram.sv
design/lcd_timing.sv
design/lcd_out.sv
design/lcd_framebuffer.sv
testbench/tb_lcd_framebuffer.sv

//--- Bender.yml
package:
  name: lcd_framebuffer

sources:
  - design/fb_pkg.sv
  - design/fb_regs.sv
  - design/draw_engine.sv
  - design/frame_ram.sv
  - design/lcd_timing.sv
  - design/lcd_out.sv
  - design/lcd_framebuffer.sv
  - target: test
    files:
      - testbench/tb_lcd_framebuffer.sv

//--- testbench/tb_lcd_framebuffer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_framebuffer;
    import fb_pkg::*;

    localparam int H_ACTIVE       = 32;
    localparam int V_ACTIVE       = 8;
    localparam int H_FRONT        = 4;
    localparam int H_SYNC         = 2;
    localparam int H_BACK         = 3;
    localparam int V_FRONT        = 1;
    localparam int V_SYNC         = 1;
    localparam int V_BACK         = 1;
    localparam int H_TOTAL        = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int PIX_N          = H_ACTIVE * V_ACTIVE;
    localparam int TIMEOUT_CYCLES = 20000;    // about 40 frames of 451 cycles

    logic       pclk;
    logic       resetn;
    reg_addr_t  s_awaddr;
    logic       s_awvalid;
    logic       s_awready;
    reg_data_t  s_wdata;
    reg_strb_t  s_wstrb;
    logic       s_wvalid;
    logic       s_wready;
    logic       s_bvalid;
    logic [1:0] s_bresp;
    logic       s_bready;
    reg_addr_t  s_araddr;
    logic       s_arvalid;
    logic       s_arready;
    reg_data_t  s_rdata;
    logic       s_rvalid;
    logic [1:0] s_rresp;
    logic       s_rready;
    logic       lcd_de;
    logic       lcd_hsync;
    logic       lcd_vsync;
    logic [4:0] lcd_r;
    logic [5:0] lcd_g;
    logic [4:0] lcd_b;

    pixel_t      model [PIX_N];    // expected frame contents
    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          cycles;
    logic        check_en;
    int          pix_checked;
    int          de_run;
    int          de_line;
    int          hs_low;
    int          vs_low;
    logic        de_prev;
    logic        hs_prev;
    logic        vs_prev;
    event        frame_end;

    lcd_framebuffer #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) i_dut (
        .pclk        (pclk),
        .resetn      (resetn),
        .s_awaddr_i  (s_awaddr),
        .s_awvalid_i (s_awvalid),
        .s_awready_o (s_awready),
        .s_wdata_i   (s_wdata),
        .s_wstrb_i   (s_wstrb),
        .s_wvalid_i  (s_wvalid),
        .s_wready_o  (s_wready),
        .s_bvalid_o  (s_bvalid),
        .s_bresp_o   (s_bresp),
        .s_bready_i  (s_bready),
        .s_araddr_i  (s_araddr),
        .s_arvalid_i (s_arvalid),
        .s_arready_o (s_arready),
        .s_rdata_o   (s_rdata),
        .s_rvalid_o  (s_rvalid),
        .s_rresp_o   (s_rresp),
        .s_rready_i  (s_rready),
        .lcd_de_o    (lcd_de),
        .lcd_hsync_o (lcd_hsync),
        .lcd_vsync_o (lcd_vsync),
        .lcd_r_o     (lcd_r),
        .lcd_g_o     (lcd_g),
        .lcd_b_o     (lcd_b)
    );

    always #4 pclk = ~pclk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // rgb888 to rgb565, dropped bits or'ed into the lowest kept bit
    function automatic pixel_t rgb565_of(input color24_t c);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        r = c[23:19];
        g = c[15:10];
        b = c[7:3];
        r[0] = r[0] | (|c[18:16]);
        g[0] = g[0] | (|c[9:8]);
        b[0] = b[0] | (|c[2:0]);
        return {r, g, b};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("at %0t: %s", $time, what);
        end
    endtask

    // starts and ends on a falling edge, bready held low for hold cycles
    task automatic write_reg(input reg_addr_t addr, input reg_data_t data,
                             input reg_strb_t strb, input int hold);
        s_awaddr  = addr;
        s_wdata   = data;
        s_wstrb   = strb;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        s_bready  = 1'b0;
        while (!s_awready) @(negedge pclk);
        check_value("s_wready_o", 1, s_wready);     // raised with awready
        @(negedge pclk);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        check_value("s_wready_o", 0, s_wready);     // single cycle
        for (int i = 0; i < hold; i++) begin
            check_value("s_bvalid_o", 1, s_bvalid);
            @(negedge pclk);
        end
        check_value("s_bvalid_o", 1, s_bvalid);
        check_value("s_bresp_o", 0, s_bresp);
        s_bready = 1'b1;
        @(negedge pclk);
        s_bready = 1'b0;
        check_value("s_bvalid_o", 0, s_bvalid);
    endtask

    task automatic read_reg(input reg_addr_t addr, input int hold, output reg_data_t data);
        s_araddr  = addr;
        s_arvalid = 1'b1;
        s_rready  = 1'b0;
        while (!s_arready) @(negedge pclk);
        @(negedge pclk);
        s_arvalid = 1'b0;
        data = s_rdata;
        for (int i = 0; i < hold; i++) begin
            check_value("s_rvalid_o", 1, s_rvalid);
            check_value("s_rdata_o", data, s_rdata);   // held while stalled
            @(negedge pclk);
        end
        check_value("s_rvalid_o", 1, s_rvalid);
        check_value("s_rresp_o", 0, s_rresp);
        data = s_rdata;
        s_rready = 1'b1;
        @(negedge pclk);
        s_rready = 1'b0;
        check_value("s_rvalid_o", 0, s_rvalid);
    endtask

    task automatic wait_idle(output logic saw_busy);
        reg_data_t d;
        saw_busy = 1'b0;
        do begin
            read_reg(REG_CTRL, 0, d);
            if (d[CTRL_BUSY_BIT])
                saw_busy = 1'b1;
        end while (d[CTRL_BUSY_BIT]);
    endtask

    task automatic draw_point(input int x, input int y, input color24_t c);
        logic seen;
        write_reg(REG_POINT, {y[15:0], x[15:0]}, 4'hF, 0);
        write_reg(REG_CTRL, 32'(1) << CTRL_POINT_BIT, 4'hF, 0);
        wait_idle(seen);
        write_reg(REG_CTRL, '0, 4'hF, 0);   // re-arm
        if (x < H_ACTIVE && y < V_ACTIVE)
            model[y * H_ACTIVE + x] = rgb565_of(c);
    endtask

    task automatic fill_model(input color24_t c);
        for (int i = 0; i < PIX_N; i++)
            model[i] = rgb565_of(c);
    endtask

    // compares one whole frame that started after the last drawing
    task automatic check_frame();
        @(frame_end);
        pix_checked = 0;
        check_en    = 1'b1;
        @(frame_end);
        check_en = 1'b0;
        check_value("pixels checked per frame", PIX_N, pix_checked);
    endtask

    // screen position from DE and sync edges only
    always @(negedge pclk) begin
        if (resetn) begin
            if (lcd_de) begin
                if (check_en) begin
                    check_value("lcd pixel", model[de_line * H_ACTIVE + de_run],
                                {lcd_r, lcd_g, lcd_b});
                    pix_checked++;
                end
                de_run++;
            end else begin
                check_value("lcd rgb outside DE", 0, {lcd_r, lcd_g, lcd_b});
                if (de_prev) begin
                    check_value("lcd_de_o run length", H_ACTIVE, de_run);
                    de_run = 0;
                    de_line++;
                end
            end
            if (!lcd_hsync) begin
                hs_low++;
            end else if (!hs_prev) begin
                check_value("lcd_hsync_o low cycles", H_SYNC, hs_low);
                hs_low = 0;
            end
            if (!lcd_vsync) begin
                vs_low++;
            end else if (!vs_prev) begin
                check_value("lcd_vsync_o low cycles", V_SYNC * H_TOTAL, vs_low);
                vs_low = 0;
            end
            de_prev = lcd_de;
            hs_prev = lcd_hsync;
            if (!lcd_vsync && vs_prev) begin
                check_value("lcd_de_o lines per frame", V_ACTIVE, de_line);
                de_line = 0;
                -> frame_end;
            end
            vs_prev = lcd_vsync;
        end
    end

    always @(posedge pclk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        reg_data_t d;
        color24_t  c1;
        color24_t  c2;
        color24_t  c3;
        color24_t  c4;
        logic      seen;
        int        x;
        int        y;

        pclk = 1'b0;
        resetn = 1'b0;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        lcg_state = 32'h8fd5_ba03;
        errors = 0;
        checks = 0;
        cycles = 0;
        check_en = 1'b0;
        pix_checked = 0;
        de_run = 0;
        de_line = 0;
        hs_low = 0;
        vs_low = 0;
        de_prev = 1'b0;
        hs_prev = 1'b1;
        vs_prev = 1'b1;

        repeat (10) @(negedge pclk);
        check_value("lcd_de_o", 0, lcd_de);
        check_value("lcd_hsync_o", 1, lcd_hsync);
        check_value("lcd_vsync_o", 1, lcd_vsync);
        resetn = 1'b1;
        @(negedge pclk);

        // register read back and strobes
        read_reg(REG_CTRL, 0, d);
        check_value("CTRL after reset", 32'h0, d);
        write_reg(REG_COLOR, 32'h0012_3456, 4'hF, 0);
        read_reg(REG_COLOR, 0, d);
        check_value("COLOR", 32'h0012_3456, d);
        write_reg(REG_COLOR, 32'hAABB_CCDD, 4'b0010, 0);
        read_reg(REG_COLOR, 0, d);
        check_value("COLOR after strobe 0010", 32'h0012_CC56, d);
        write_reg(REG_COLOR, 32'hFF00_0000, 4'b1000, 0);
        read_reg(REG_COLOR, 0, d);
        check_value("COLOR upper byte", 32'h0012_CC56, d);
        write_reg(REG_POINT, 32'h0005_0003, 4'hF, 0);
        write_reg(REG_POINT, 32'h0007_0000, 4'b0100, 0);
        read_reg(REG_POINT, 0, d);
        check_value("POINT", 32'h0007_0003, d);
        write_reg(8'h20, 32'hDEAD_BEEF, 4'hF, 0);
        read_reg(8'h20, 0, d);
        check_value("unmapped 0x20", 32'h0, d);
        read_reg(8'h04, 0, d);
        check_value("unmapped 0x04", 32'h0, d);

        // fill with a random colour
        c1 = color24_t'(lcg_next());
        write_reg(REG_COLOR, 32'(c1), 4'hF, 0);
        write_reg(REG_CTRL, 32'(1) << CTRL_FILL_BIT, 4'hF, 0);
        wait_idle(seen);
        check_true(seen, "fill request never showed busy in CTRL");
        write_reg(REG_CTRL, '0, 4'hF, 0);
        fill_model(c1);
        check_frame();

        // points in a second colour, two of them off screen
        c2 = c1 ^ 24'h80_80_80 ^ (color24_t'(lcg_next()) & 24'h7F_7F_7F);
        write_reg(REG_COLOR, 32'(c2), 4'hF, 0);
        for (int i = 0; i < 4; i++) begin
            x = int'(lcg_next() % H_ACTIVE);
            y = int'(lcg_next() % V_ACTIVE);
            draw_point(x, y, c2);
        end
        draw_point(H_ACTIVE + int'(lcg_next() % 16), int'(lcg_next() % V_ACTIVE), c2);
        draw_point(int'(lcg_next() % H_ACTIVE), V_ACTIVE + int'(lcg_next() % 4), c2);
        check_frame();

        // both requests at once, point colour changed while the fill runs
        c3 = color24_t'(lcg_next());
        c4 = c3 ^ 24'h80_80_80;
        x = int'(lcg_next() % H_ACTIVE);
        y = int'(lcg_next() % V_ACTIVE);
        write_reg(REG_COLOR, 32'(c3), 4'hF, 0);
        write_reg(REG_POINT, {y[15:0], x[15:0]}, 4'hF, 0);
        write_reg(REG_CTRL, (32'(1) << CTRL_FILL_BIT) | (32'(1) << CTRL_POINT_BIT),
                  4'hF, 0);
        write_reg(REG_COLOR, 32'(c4), 4'hF, 0);
        wait_idle(seen);
        check_true(seen, "combined request never showed busy in CTRL");
        write_reg(REG_CTRL, '0, 4'hF, 0);
        fill_model(c3);
        model[y * H_ACTIVE + x] = rgb565_of(c4);
        check_frame();

        // stalled responses
        write_reg(REG_POINT, 32'h0003_0011, 4'hF, 6);
        read_reg(REG_POINT, 6, d);
        check_value("POINT after stall", 32'h0003_0011, d);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/lcd_framebuffer.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_framebuffer #(
    parameter int H_ACTIVE = 32,
    parameter int V_ACTIVE = 8,
    parameter int H_FRONT  = 4,
    parameter int H_SYNC   = 2,
    parameter int H_BACK   = 3,
    parameter int V_FRONT  = 1,
    parameter int V_SYNC   = 1,
    parameter int V_BACK   = 1
) (
    input  wire                    pclk,
    input  wire                    resetn,
    input  wire fb_pkg::reg_addr_t s_awaddr_i,
    input  wire                    s_awvalid_i,
    output logic                   s_awready_o,
    input  wire fb_pkg::reg_data_t s_wdata_i,
    input  wire fb_pkg::reg_strb_t s_wstrb_i,
    input  wire                    s_wvalid_i,
    output logic                   s_wready_o,
    output logic                   s_bvalid_o,
    output logic [1:0]             s_bresp_o,
    input  wire                    s_bready_i,
    input  wire fb_pkg::reg_addr_t s_araddr_i,
    input  wire                    s_arvalid_i,
    output logic                   s_arready_o,
    output fb_pkg::reg_data_t      s_rdata_o,
    output logic                   s_rvalid_o,
    output logic [1:0]             s_rresp_o,
    input  wire                    s_rready_i,
    output logic                   lcd_de_o,
    output logic                   lcd_hsync_o,
    output logic                   lcd_vsync_o,
    output logic [4:0]             lcd_r_o,
    output logic [5:0]             lcd_g_o,
    output logic [4:0]             lcd_b_o
);
    import fb_pkg::*;

    localparam int ADDR_W = $clog2(H_ACTIVE * V_ACTIVE);

    logic              fill_req;
    logic              point_req;
    logic              busy;
    pixel_t            color;
    coord_t            point_x;
    coord_t            point_y;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    pixel_t            wr_data;
    logic [ADDR_W-1:0] rd_addr;
    pixel_t            rd_data;
    logic              active;
    logic              hsync;
    logic              vsync;

    fb_regs i_regs (
        .pclk        (pclk),
        .resetn      (resetn),
        .s_awaddr_i  (s_awaddr_i),
        .s_awvalid_i (s_awvalid_i),
        .s_awready_o (s_awready_o),
        .s_wdata_i   (s_wdata_i),
        .s_wstrb_i   (s_wstrb_i),
        .s_wvalid_i  (s_wvalid_i),
        .s_wready_o  (s_wready_o),
        .s_bvalid_o  (s_bvalid_o),
        .s_bresp_o   (s_bresp_o),
        .s_bready_i  (s_bready_i),
        .s_araddr_i  (s_araddr_i),
        .s_arvalid_i (s_arvalid_i),
        .s_arready_o (s_arready_o),
        .s_rdata_o   (s_rdata_o),
        .s_rvalid_o  (s_rvalid_o),
        .s_rresp_o   (s_rresp_o),
        .s_rready_i  (s_rready_i),
        .fill_req_o  (fill_req),
        .point_req_o (point_req),
        .color_o     (color),
        .point_x_o   (point_x),
        .point_y_o   (point_y),
        .busy_i      (busy)
    );

    draw_engine #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) i_draw (
        .pclk        (pclk),
        .resetn      (resetn),
        .fill_req_i  (fill_req),
        .point_req_i (point_req),
        .color_i     (color),
        .point_x_i   (point_x),
        .point_y_i   (point_y),
        .busy_o      (busy),
        .wr_en_o     (wr_en),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data)
    );

    frame_ram #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) i_ram (
        .pclk      (pclk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    lcd_timing #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) i_timing (
        .pclk      (pclk),
        .resetn    (resetn),
        .rd_addr_o (rd_addr),
        .active_o  (active),
        .hsync_o   (hsync),
        .vsync_o   (vsync)
    );

    lcd_out i_out (
        .pclk        (pclk),
        .resetn      (resetn),
        .active_i    (active),
        .hsync_i     (hsync),
        .vsync_i     (vsync),
        .pixel_i     (rd_data),
        .lcd_de_o    (lcd_de_o),
        .lcd_hsync_o (lcd_hsync_o),
        .lcd_vsync_o (lcd_vsync_o),
        .lcd_r_o     (lcd_r_o),
        .lcd_g_o     (lcd_g_o),
        .lcd_b_o     (lcd_b_o)
    );

endmodule

`default_nettype wire

//--- design/lcd_out.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_out (
    input  wire                 pclk,
    input  wire                 resetn,
    input  wire                 active_i,
    input  wire                 hsync_i,
    input  wire                 vsync_i,
    input  wire fb_pkg::pixel_t pixel_i,
    output logic                lcd_de_o,
    output logic                lcd_hsync_o,
    output logic                lcd_vsync_o,
    output logic [4:0]          lcd_r_o,
    output logic [5:0]          lcd_g_o,
    output logic [4:0]          lcd_b_o
);
    logic act_q;
    logic hs_q;
    logic vs_q;

    always_ff @(posedge pclk) begin
        if (!resetn) begin
            act_q       <= 1'b0;
            hs_q        <= 1'b0;
            vs_q        <= 1'b0;
            lcd_de_o    <= 1'b0;
            lcd_hsync_o <= 1'b1;
            lcd_vsync_o <= 1'b1;
            {lcd_r_o, lcd_g_o, lcd_b_o} <= '0;
        end else begin
            act_q       <= active_i;    // matches ram read latency
            hs_q        <= hsync_i;
            vs_q        <= vsync_i;
            lcd_de_o    <= act_q;
            lcd_hsync_o <= ~hs_q;       // pins active low
            lcd_vsync_o <= ~vs_q;
            {lcd_r_o, lcd_g_o, lcd_b_o} <= act_q ? pixel_i : '0;   // blank outside DE
        end
    end

endmodule

`default_nettype wire

//--- design/lcd_timing.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_timing #(
    parameter int  H_ACTIVE = 32,
    parameter int  V_ACTIVE = 8,
    parameter int  H_FRONT  = 4,
    parameter int  H_SYNC   = 2,
    parameter int  H_BACK   = 3,
    parameter int  V_FRONT  = 1,
    parameter int  V_SYNC   = 1,
    parameter int  V_BACK   = 1,
    localparam int ADDR_W   = $clog2(H_ACTIVE * V_ACTIVE)
) (
    input  wire               pclk,
    input  wire               resetn,
    output logic [ADDR_W-1:0] rd_addr_o,
    output logic              active_o,
    output logic              hsync_o,
    output logic              vsync_o
);
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HC_W     = $clog2(H_TOTAL);
    localparam int VC_W     = $clog2(V_TOTAL);
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int VS_START = V_ACTIVE + V_FRONT;

    logic [HC_W-1:0] hcnt_q;
    logic [VC_W-1:0] vcnt_q;
    logic            h_last;
    logic            v_last;
    logic [31:0]     lin;

    assign h_last = (hcnt_q == HC_W'(H_TOTAL - 1));
    assign v_last = (vcnt_q == VC_W'(V_TOTAL - 1));

    always_ff @(posedge pclk) begin
        if (!resetn) begin
            hcnt_q <= '0;
            vcnt_q <= '0;
        end else if (h_last) begin
            hcnt_q <= '0;
            vcnt_q <= v_last ? '0 : vcnt_q + 1'b1;  // next line
        end else begin
            hcnt_q <= hcnt_q + 1'b1;
        end
    end

    // active area sits at the start of each line and frame
    assign active_o  = (hcnt_q < H_ACTIVE) && (vcnt_q < V_ACTIVE);
    assign hsync_o   = (hcnt_q >= HS_START) && (hcnt_q < HS_START + H_SYNC);
    assign vsync_o   = (vcnt_q >= VS_START) && (vcnt_q < VS_START + V_SYNC);
    assign lin       = 32'(vcnt_q) * H_ACTIVE + 32'(hcnt_q);
    assign rd_addr_o = active_o ? lin[ADDR_W-1:0] : '0;

    a_cnt_range: assert property (@(posedge pclk) disable iff (!resetn)
        (hcnt_q < H_TOTAL) && (vcnt_q < V_TOTAL));

endmodule

`default_nettype wire

//--- design/frame_ram.sv
`timescale 1ns/10ps
`default_nettype none

module frame_ram #(
    parameter int  H_ACTIVE = 32,
    parameter int  V_ACTIVE = 8,
    localparam int ADDR_W   = $clog2(H_ACTIVE * V_ACTIVE)
) (
    input  wire                 pclk,
    input  wire                 wr_en_i,
    input  wire [ADDR_W-1:0]    wr_addr_i,
    input  wire fb_pkg::pixel_t wr_data_i,
    input  wire [ADDR_W-1:0]    rd_addr_i,
    output fb_pkg::pixel_t      rd_data_o
);
    import fb_pkg::*;

    pixel_t mem_q [H_ACTIVE * V_ACTIVE];

    // read-first, a colliding read sees the old pixel
    always_ff @(posedge pclk) begin
        if (wr_en_i)
            mem_q[wr_addr_i] <= wr_data_i;
        rd_data_o <= mem_q[rd_addr_i];
    end

endmodule

`default_nettype wire

//--- design/draw_engine.sv
`timescale 1ns/10ps
`default_nettype none

module draw_engine #(
    parameter int  H_ACTIVE = 32,
    parameter int  V_ACTIVE = 8,
    localparam int ADDR_W   = $clog2(H_ACTIVE * V_ACTIVE)
) (
    input  wire                 pclk,
    input  wire                 resetn,
    input  wire                 fill_req_i,
    input  wire                 point_req_i,
    input  wire fb_pkg::pixel_t color_i,
    input  wire fb_pkg::coord_t point_x_i,
    input  wire fb_pkg::coord_t point_y_i,
    output logic                busy_o,
    output logic                wr_en_o,
    output logic [ADDR_W-1:0]   wr_addr_o,
    output fb_pkg::pixel_t      wr_data_o
);
    import fb_pkg::*;

    localparam int PIX_N = H_ACTIVE * V_ACTIVE;

    draw_state_t       state_q;
    logic              fill_d_q;
    logic              point_d_q;
    logic              fill_pend_q;
    logic              point_pend_q;
    logic [ADDR_W-1:0] cnt_q;
    logic [ADDR_W-1:0] pt_addr_q;
    logic              pt_ok_q;
    pixel_t            col_q;
    logic [31:0]       pt_lin;
    logic              pt_in_range;
    logic              take_fill;
    logic              take_point;

    assign pt_lin      = 32'(point_y_i) * H_ACTIVE + 32'(point_x_i);
    assign pt_in_range = (point_x_i < H_ACTIVE) && (point_y_i < V_ACTIVE);
    assign take_fill   = (state_q == DRAW_IDLE) && fill_pend_q;
    assign take_point  = (state_q == DRAW_IDLE) && !fill_pend_q && point_pend_q;

    // rising edge of a request bit arms it
    always_ff @(posedge pclk) begin
        if (!resetn) begin
            fill_d_q     <= 1'b0;
            point_d_q    <= 1'b0;
            fill_pend_q  <= 1'b0;
            point_pend_q <= 1'b0;
        end else begin
            fill_d_q     <= fill_req_i;
            point_d_q    <= point_req_i;
            fill_pend_q  <= (fill_pend_q & ~take_fill) | (fill_req_i & ~fill_d_q);
            point_pend_q <= (point_pend_q & ~take_point) | (point_req_i & ~point_d_q);
        end
    end

    always_ff @(posedge pclk) begin
        if (!resetn) begin
            state_q <= DRAW_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                DRAW_IDLE: begin
                    cnt_q <= '0;
                    if (take_fill)
                        state_q <= DRAW_FILL;   // fill wins over point
                    else if (take_point)
                        state_q <= DRAW_POINT;
                end
                DRAW_FILL: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == ADDR_W'(PIX_N - 1))
                        state_q <= DRAW_IDLE;
                end
                DRAW_POINT: state_q <= DRAW_IDLE;   // single write
                default:    state_q <= DRAW_IDLE;
            endcase
        end
    end

    // operands held for the whole operation
    always_ff @(posedge pclk) begin
        if (take_fill || take_point) begin
            col_q     <= color_i;
            pt_addr_q <= pt_lin[ADDR_W-1:0];
            pt_ok_q   <= pt_in_range;
        end
    end

    assign busy_o    = (state_q != DRAW_IDLE);
    assign wr_en_o   = (state_q == DRAW_FILL) || (state_q == DRAW_POINT && pt_ok_q);
    assign wr_addr_o = (state_q == DRAW_FILL) ? cnt_q : pt_addr_q;
    assign wr_data_o = col_q;

    a_wr_in_frame: assert property (@(posedge pclk) disable iff (!resetn)
        wr_en_o |-> 32'(wr_addr_o) < PIX_N);

endmodule

`default_nettype wire

//--- design/fb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module fb_regs (
    input  wire                    pclk,
    input  wire                    resetn,
    input  wire fb_pkg::reg_addr_t s_awaddr_i,
    input  wire                    s_awvalid_i,
    output logic                   s_awready_o,
    input  wire fb_pkg::reg_data_t s_wdata_i,
    input  wire fb_pkg::reg_strb_t s_wstrb_i,
    input  wire                    s_wvalid_i,
    output logic                   s_wready_o,
    output logic                   s_bvalid_o,
    output logic [1:0]             s_bresp_o,
    input  wire                    s_bready_i,
    input  wire fb_pkg::reg_addr_t s_araddr_i,
    input  wire                    s_arvalid_i,
    output logic                   s_arready_o,
    output fb_pkg::reg_data_t      s_rdata_o,
    output logic                   s_rvalid_o,
    output logic [1:0]             s_rresp_o,
    input  wire                    s_rready_i,
    output logic                   fill_req_o,
    output logic                   point_req_o,
    output fb_pkg::pixel_t         color_o,
    output fb_pkg::coord_t         point_x_o,
    output fb_pkg::coord_t         point_y_o,
    input  wire                    busy_i
);
    import fb_pkg::*;

    reg_data_t ctrl_q;
    color24_t  color_q;
    reg_data_t point_q;
    reg_data_t rd_word;
    logic      aw_ready_q;
    logic      ar_ready_q;
    logic      wr_fire;
    logic      rd_fire;

    function automatic reg_data_t merge_strb(reg_data_t old, reg_data_t data,
                                             reg_strb_t strb);
        reg_data_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (strb[i])
                res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    assign wr_fire = aw_ready_q & s_awvalid_i & s_wvalid_i;
    assign rd_fire = ar_ready_q & s_arvalid_i;

    // write address and data are taken together
    always_ff @(posedge pclk) begin
        if (!resetn) begin
            aw_ready_q <= 1'b0;
            s_bvalid_o <= 1'b0;
        end else begin
            aw_ready_q <= s_awvalid_i & s_wvalid_i & ~s_bvalid_o & ~aw_ready_q;
            if (wr_fire)
                s_bvalid_o <= 1'b1;
            else if (s_bready_i)
                s_bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge pclk) begin
        if (!resetn) begin
            ar_ready_q <= 1'b0;
            s_rvalid_o <= 1'b0;
        end else begin
            ar_ready_q <= s_arvalid_i & ~s_rvalid_o & ~ar_ready_q;
            if (rd_fire)
                s_rvalid_o <= 1'b1;
            else if (s_rready_i)
                s_rvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge pclk) begin
        if (!resetn) begin
            ctrl_q  <= '0;
            color_q <= '0;
            point_q <= '0;
        end else if (wr_fire) begin
            case (s_awaddr_i)
                REG_CTRL:  ctrl_q  <= merge_strb(ctrl_q, s_wdata_i, s_wstrb_i);
                REG_COLOR: color_q <= color24_t'(merge_strb({8'h00, color_q}, s_wdata_i,
                                                            s_wstrb_i));
                REG_POINT: point_q <= merge_strb(point_q, s_wdata_i, s_wstrb_i);
                default:   ;                // unmapped, dropped
            endcase
        end
    end

    always_comb begin
        rd_word = '0;
        case (s_araddr_i)
            REG_CTRL: begin
                rd_word = ctrl_q;
                rd_word[CTRL_BUSY_BIT] = busy_i;   // live engine status
            end
            REG_COLOR: rd_word = {8'h00, color_q};
            REG_POINT: rd_word = point_q;
            default:   rd_word = '0;
        endcase
    end

    always_ff @(posedge pclk) begin
        if (rd_fire)
            s_rdata_o <= rd_word;
    end

    assign s_awready_o = aw_ready_q;
    assign s_wready_o  = aw_ready_q;
    assign s_arready_o = ar_ready_q;
    assign s_bresp_o   = 2'b00;         // always OKAY
    assign s_rresp_o   = 2'b00;

    assign fill_req_o  = ctrl_q[CTRL_FILL_BIT];
    assign point_req_o = ctrl_q[CTRL_POINT_BIT];
    assign point_x_o   = point_q[15:0];
    assign point_y_o   = point_q[31:16];

    // dropped low bits of each channel fold into its lowest kept bit
    assign color_o = {color_q[23:20], |color_q[19:16],
                      color_q[15:11], |color_q[10:8],
                      color_q[7:4],   |color_q[3:0]};

    a_bvalid_hold: assert property (@(posedge pclk) disable iff (!resetn)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o && !s_awready_o);

    a_rvalid_hold: assert property (@(posedge pclk) disable iff (!resetn)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o));

endmodule

`default_nettype wire

//--- design/fb_pkg.sv
`default_nettype none

package fb_pkg;

    typedef logic [31:0] reg_data_t;
    typedef logic [7:0]  reg_addr_t;    // byte address
    typedef logic [3:0]  reg_strb_t;
    typedef logic [15:0] pixel_t;       // rgb565
    typedef logic [23:0] color24_t;     // rgb888
    typedef logic [15:0] coord_t;

    localparam reg_addr_t REG_CTRL  = 8'h00;
    localparam reg_addr_t REG_COLOR = 8'h0C;
    localparam reg_addr_t REG_POINT = 8'h10;    // x in [15:0], y in [31:16]

    localparam int CTRL_BUSY_BIT  = 0;  // read only
    localparam int CTRL_FILL_BIT  = 1;
    localparam int CTRL_POINT_BIT = 2;

    typedef enum logic [1:0] {
        DRAW_IDLE,
        DRAW_FILL,
        DRAW_POINT
    } draw_state_t;

endpackage

`default_nettype wire
